//--- filelist.f
logic/photon_pkg.sv
logic/ex_signal_sync.sv
logic/photon_counter.sv
logic/counter_config.sv
logic/sim_source.sv
logic/display_sequencer.sv
logic/lcd_bus_writer.sv
logic/photon_counter_top.sv
verification/photon_counter_properties.sv
verification/photon_counter_tb.sv

//--- logic/counter_config.sv
`timescale 1ns/1ps

module counter_config
    import photon_pkg::*;
(
    input  logic      clk_80MHz,
    input  logic      rst_n,
    input  logic      cfg_we,
    input  cfg_addr_t cfg_addr,
    input  lcd_word_t cfg_wdata,
    output lcd_word_t cfg_rdata,
    output lcd_word_t bg_colour,       // To the bus writer.
    output period_t   photon_period,   // To the simulate source.
    output period_t   sync_period
);

    //////////////////////////////////////////////////
    // Write side.
    //////////////////////////////////////////////////
    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            bg_colour     <= default_bg_colour;
            photon_period <= default_photon_period;
            sync_period   <= default_sync_period;
        end else if (cfg_we) begin
            case (cfg_addr)
                2'd0: bg_colour <= cfg_wdata;
                2'd1: photon_period <= {photon_period[23:16], cfg_wdata};  // Low half.
                2'd2: sync_period <= {8'h00, cfg_wdata};  // Upper byte cleared.
                default: begin
                    // Address 3 is read only.
                end
            endcase
        end
    end

    // Readback mux.
    always_comb begin
        case (cfg_addr)
            2'd0:    cfg_rdata = bg_colour;
            2'd1:    cfg_rdata = photon_period[15:0];
            2'd2:    cfg_rdata = sync_period[15:0];
            default: cfg_rdata = {8'h00, sync_period[23:16]};  // Sync upper byte.
        endcase
    end

endmodule

//--- logic/display_sequencer.sv
`timescale 1ns/1ps

module display_sequencer
    import photon_pkg::*;
(
    input  logic          clk_80MHz,
    input  logic          rst_n,
    input  logic          frame_done,
    input  photon_count_t count_latched,
    output logic          draw_req,
    output draw_job_e     draw_job,     // Stable while draw_req is high.
    output photon_count_t draw_count,
    input  logic          draw_ack
);

    seq_state_e state;
    logic       pending;      // Single waiting frame. Older ones dropped.
    logic       start_count;  // Raise draw_req for a count job.

    assign start_count = (state == seq_wait_frame) && (frame_done || pending);

    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            state    <= seq_draw_fixed;
            draw_req <= 1'b0;
            draw_job <= job_idle;
            pending  <= 1'b0;
        end else begin
            case (state)
                seq_draw_fixed: begin
                    if (!draw_req && !draw_ack) begin
                        draw_req <= 1'b1;              // Static screen once.
                        draw_job <= job_fixed;
                    end else if (draw_req && draw_ack) begin
                        draw_req <= 1'b0;
                        state    <= seq_release;
                    end
                end
                seq_wait_frame: begin
                    if (start_count) begin
                        draw_req <= 1'b1;
                        draw_job <= job_count;
                        pending  <= 1'b0;
                        state    <= seq_req_count;
                    end
                end
                seq_req_count: begin
                    if (draw_ack) begin
                        draw_req <= 1'b0;              // Second phase.
                        state    <= seq_release;
                    end
                end
                default: begin
                    // Writer must drop ack before the next request.
                    if (!draw_ack) begin
                        draw_job <= job_idle;
                        state    <= seq_wait_frame;
                    end
                end
            endcase
            if (frame_done && (state != seq_wait_frame)) begin
                pending <= 1'b1;  // Back-pressure.
            end
        end
    end

    // Count snapshot for the job.
    always_ff @(posedge clk_80MHz) begin
        if (start_count) begin
            draw_count <= count_latched;
        end
    end

endmodule

//--- logic/ex_signal_sync.sv
`timescale 1ns/1ps

module ex_signal_sync (
    input  logic clk_80MHz,
    input  logic rst_n,
    input  logic sig_in,    // Asynchronous pin.
    output logic sig_edge   // One clock per rising edge.
);

    logic meta_q;     // First stage, may go metastable.
    logic sync_q;     // Second stage, safe to use.
    logic delay_q;    // Previous synced level.

    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            meta_q   <= 1'b0;
            sync_q   <= 1'b0;
            delay_q  <= 1'b0;
            sig_edge <= 1'b0;
        end else begin
            meta_q   <= sig_in;
            sync_q   <= meta_q;
            delay_q  <= sync_q;
            // Low to high on the synced copy.
            sig_edge <= sync_q & ~delay_q;  // Pulse lands 3 clocks after the pin.
        end
    end

endmodule

//--- logic/lcd_bus_writer.sv
`timescale 1ns/1ps

module lcd_bus_writer
    import photon_pkg::*;
(
    input  logic          clk_80MHz,
    input  logic          rst_n,
    input  logic          draw_req,
    input  draw_job_e     draw_job,
    input  photon_count_t draw_count,
    input  lcd_word_t     bg_colour,
    output logic          draw_ack,
    output logic          LCD_RST,    // Panel reset, active low.
    output logic          BL_CTR,     // Backlight enable.
    output logic          LCD_CS,
    output logic          LCD_RS,     // Low for command, high for data.
    output logic          LCD_WR,     // Panel latches on the rising edge.
    output logic          LCD_RD,
    output lcd_word_t     LCD_DATA
);

    wr_state_e  state;
    logic [2:0] word_idx;      // 0 is the command word.
    logic [1:0] phase_cnt;     // Clocks spent in the current WR phase.
    logic [2:0] last_idx;
    logic [2:0] next_idx;
    lcd_word_t  next_word;
    logic       panel_on;
    logic       phase_end;

    assign phase_end = (phase_cnt == 2'(wr_phase_cycles - 1));

    // Data word selection.
    always_comb begin
        last_idx = (draw_job == job_fixed) ? 3'(fixed_word_count) : 3'd2;
        next_idx = word_idx + 3'd1;
        if (draw_job == job_count) begin
            next_word = (next_idx == 3'd1) ? draw_count[31:16] : draw_count[15:0];
        end else begin
            next_word = bg_colour;  // Fill colour for the fixed screen.
        end
    end

    //////////////////////////////////////////////////
    // Bus cycle FSM.
    //////////////////////////////////////////////////
    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            state     <= wr_idle;
            word_idx  <= '0;
            phase_cnt <= '0;
            draw_ack  <= 1'b0;
            panel_on  <= 1'b0;
            LCD_CS    <= 1'b1;
            LCD_RS    <= 1'b1;
            LCD_WR    <= 1'b1;
            LCD_DATA  <= '0;
        end else begin
            panel_on <= 1'b1;  // Backlight on once out of reset.
            case (state)
                wr_idle: begin
                    if (draw_req) begin
                        LCD_CS    <= 1'b0;              // Held for the whole job.
                        LCD_RS    <= 1'b0;
                        LCD_DATA  <= lcd_cmd_mem_write;
                        LCD_WR    <= 1'b0;
                        word_idx  <= '0;
                        phase_cnt <= '0;
                        state     <= wr_low;
                    end
                end
                wr_low: begin
                    if (phase_end) begin
                        LCD_WR    <= 1'b1;              // Word latched here.
                        phase_cnt <= '0;
                        state     <= wr_high;
                    end else begin
                        phase_cnt <= phase_cnt + 2'd1;
                    end
                end
                wr_high: begin
                    if (word_idx == last_idx) begin
                        draw_ack <= 1'b1;               // 1 clock after the last WR rise.
                        LCD_CS   <= 1'b1;
                        state    <= wr_ack;
                    end else if (phase_end) begin
                        word_idx  <= next_idx;
                        LCD_RS    <= 1'b1;
                        LCD_DATA  <= next_word;
                        LCD_WR    <= 1'b0;
                        phase_cnt <= '0;
                        state     <= wr_low;
                    end else begin
                        phase_cnt <= phase_cnt + 2'd1;
                    end
                end
                default: begin
                    if (!draw_req) begin
                        draw_ack <= 1'b0;               // Close the handshake.
                        state    <= wr_idle;
                    end
                end
            endcase
        end
    end

    assign LCD_RST = panel_on;
    assign BL_CTR  = panel_on;
    assign LCD_RD  = 1'b1;  // Reads are never issued.

endmodule

//--- logic/photon_counter.sv
`timescale 1ns/1ps

module photon_counter
    import photon_pkg::*;
(
    input  logic          clk_80MHz,
    input  logic          rst_n,
    input  logic          photon_edge,
    input  logic          sync_edge,      // Frame boundary.
    output photon_count_t count_latched,
    output logic          frame_done      // Latched total is valid.
);

    photon_count_t running;    // Photons so far in this frame.
    photon_count_t total;      // Running count with the current edge.

    // Saturate instead of wrapping on a very bright frame.
    always_comb begin
        if (photon_edge && (running != '1)) begin
            total = running + 1'b1;
        end else begin
            total = running;
        end
    end

    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            running    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= sync_edge;  // One clock behind the edge.
            if (sync_edge) begin
                running <= '0;          // New frame starts empty.
            end else begin
                running <= total;
            end
        end
    end

    // Total of the closing frame with any coincident photon.
    always_ff @(posedge clk_80MHz) begin
        if (sync_edge) begin
            count_latched <= total;
        end
    end

endmodule

//--- logic/photon_counter_top.sv
`timescale 1ns/1ps

module photon_counter_top
    import photon_pkg::*;
(
    input  logic      clk_80MHz,
    input  logic      rst_n,
    input  logic      photon_pulse,           // Detector pin.
    input  logic      sync_50Hz,              // Frame sync pin.
    input  logic      cfg_we,
    input  cfg_addr_t cfg_addr,
    input  lcd_word_t cfg_wdata,
    output lcd_word_t cfg_rdata,
    output logic      photon_pulse_simulate,
    output logic      sync_50Hz_simulate,
    output logic      LCD_RST,
    output logic      BL_CTR,
    output logic      LCD_CS,
    output logic      LCD_RS,
    output logic      LCD_WR,
    output logic      LCD_RD,
    output lcd_word_t LCD_DATA,
    output logic      busy                    // Draw job in flight.
);

    logic          photon_edge;
    logic          sync_edge;
    logic          frame_done;
    photon_count_t count_latched;
    logic          draw_req;
    logic          draw_ack;
    draw_job_e     draw_job;
    photon_count_t draw_count;
    lcd_word_t     bg_colour;
    period_t       photon_period;
    period_t       sync_period;

    //////////////////////////////////////////////////
    // Input synchronizers and counting.
    //////////////////////////////////////////////////
    ex_signal_sync i_photon_sync (
        .clk_80MHz (clk_80MHz),
        .rst_n     (rst_n),
        .sig_in    (photon_pulse),
        .sig_edge  (photon_edge)
    );

    ex_signal_sync i_frame_sync (
        .clk_80MHz (clk_80MHz),
        .rst_n     (rst_n),
        .sig_in    (sync_50Hz),
        .sig_edge  (sync_edge)
    );

    photon_counter i_photon_counter (
        .clk_80MHz     (clk_80MHz),
        .rst_n         (rst_n),
        .photon_edge   (photon_edge),
        .sync_edge     (sync_edge),
        .count_latched (count_latched),
        .frame_done    (frame_done)
    );

    // Registers and bench stimulus.
    counter_config i_counter_config (
        .clk_80MHz     (clk_80MHz),
        .rst_n         (rst_n),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .cfg_rdata     (cfg_rdata),
        .bg_colour     (bg_colour),
        .photon_period (photon_period),
        .sync_period   (sync_period)
    );

    sim_source i_sim_source (
        .clk_80MHz             (clk_80MHz),
        .rst_n                 (rst_n),
        .photon_period         (photon_period),
        .sync_period           (sync_period),
        .photon_pulse_simulate (photon_pulse_simulate),
        .sync_50Hz_simulate    (sync_50Hz_simulate)
    );

    //////////////////////////////////////////////////
    // Display path.
    //////////////////////////////////////////////////
    display_sequencer i_display_sequencer (
        .clk_80MHz     (clk_80MHz),
        .rst_n         (rst_n),
        .frame_done    (frame_done),
        .count_latched (count_latched),
        .draw_req      (draw_req),
        .draw_job      (draw_job),
        .draw_count    (draw_count),
        .draw_ack      (draw_ack)
    );

    lcd_bus_writer i_lcd_bus_writer (
        .clk_80MHz  (clk_80MHz),
        .rst_n      (rst_n),
        .draw_req   (draw_req),
        .draw_job   (draw_job),
        .draw_count (draw_count),
        .bg_colour  (bg_colour),
        .draw_ack   (draw_ack),
        .LCD_RST    (LCD_RST),
        .BL_CTR     (BL_CTR),
        .LCD_CS     (LCD_CS),
        .LCD_RS     (LCD_RS),
        .LCD_WR     (LCD_WR),
        .LCD_RD     (LCD_RD),
        .LCD_DATA   (LCD_DATA)
    );

    assign busy = draw_req | draw_ack;  // Covers both handshake phases.

endmodule

//--- logic/photon_pkg.sv
package photon_pkg;

    //////////////////////////////////////////////////
    // Data widths.
    //////////////////////////////////////////////////
    typedef logic [31:0] photon_count_t;   // Latched photons per frame.
    typedef logic [15:0] lcd_word_t;       // One panel bus word.
    typedef logic [23:0] period_t;         // Simulate period in clocks.
    typedef logic [1:0]  cfg_addr_t;       // Register address.

    // Draw job codes on the sequencer to writer link.
    typedef enum logic [1:0] {
        job_idle  = 2'd0,
        job_fixed = 2'd1,   // Static screen.
        job_count = 2'd2    // Photon total.
    } draw_job_e;

    typedef enum logic [1:0] {
        seq_draw_fixed,     // Fixed screen once after reset.
        seq_wait_frame,
        seq_req_count,
        seq_release         // Wait for ack low.
    } seq_state_e;

    typedef enum logic [1:0] {
        wr_idle,
        wr_low,             // WR strobe low.
        wr_high,            // WR strobe high.
        wr_ack
    } wr_state_e;

    //////////////////////////////////////////////////
    // Defaults and panel codes.
    //////////////////////////////////////////////////
    localparam period_t   default_photon_period = 24'd400;        // 200 kHz at 80 MHz.
    localparam period_t   default_sync_period   = 24'd1_600_000;  // 50 Hz at 80 MHz.
    localparam lcd_word_t default_bg_colour     = 16'h001f;       // Blue, RGB565.
    localparam lcd_word_t lcd_cmd_mem_write     = 16'h002c;
    localparam int        fixed_word_count      = 4;   // Colour words per fixed job.
    localparam int        wr_phase_cycles       = 2;   // Clocks per WR phase.

endpackage

//--- logic/sim_source.sv
`timescale 1ns/1ps

module sim_source
    import photon_pkg::*;
(
    input  logic    clk_80MHz,
    input  logic    rst_n,
    input  period_t photon_period,
    input  period_t sync_period,
    output logic    photon_pulse_simulate,  // Loop back to photon_pulse.
    output logic    sync_50Hz_simulate      // Loop back to sync_50Hz.
);

    period_t    cnt [2];        // Index 0 photon, 1 sync.
    period_t    cur [2];        // Period of the running cycle.
    period_t    req [2];        // Period from the registers.
    logic [1:0] pulse;

    assign req[0] = photon_period;
    assign req[1] = sync_period;

    always_ff @(posedge clk_80MHz or negedge rst_n) begin
        if (!rst_n) begin
            cnt[0] <= '0;
            cnt[1] <= '0;
            cur[0] <= default_photon_period;
            cur[1] <= default_sync_period;
            pulse  <= '0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (cnt[i] + 1'b1 >= cur[i]) begin  // Terminal count.
                    cnt[i]   <= '0;
                    cur[i]   <= req[i];             // New period at the wrap only.
                    pulse[i] <= 1'b1;
                end else begin
                    cnt[i]   <= cnt[i] + 1'b1;
                    pulse[i] <= 1'b0;
                end
            end
        end
    end

    assign photon_pulse_simulate = pulse[0];
    assign sync_50Hz_simulate    = pulse[1];

endmodule

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module photon_counter_tb \
        -f filelist.f -o sim_photon \
    && ./obj_dir/sim_photon > sim.log 2>&1 \
    && ! grep -q "tests failed" sim.log \
    && grep -q "all tests passed" sim.log \
    && { cat sim.log; echo "simulation PASS"; } \
    || { cat sim.log 2>/dev/null; echo "simulation FAIL"; exit 1; }

//--- verification/photon_counter_properties.sv
`timescale 1ns/1ps

module photon_counter_properties
    import photon_pkg::*;
(
    input  logic      clk_80MHz,
    input  logic      rst_n,
    input  logic      draw_req,
    input  draw_job_e draw_job,
    input  logic      draw_ack
);

    //////////////////////////////////////////////////
    // Four-phase req/ack rules.
    //////////////////////////////////////////////////
    job_stable_check: assert property (
        @(posedge clk_80MHz) disable iff (!rst_n)
        (draw_req && $past(draw_req)) |-> $stable(draw_job)    // Job held during request.
    ) else $error("draw_job changed while draw_req was high");

    req_rise_check: assert property (
        @(posedge clk_80MHz) disable iff (!rst_n)
        $rose(draw_req) |-> !draw_ack
    ) else $error("draw_req rose while draw_ack was still high");

    // Ack closes only after the request is gone.
    ack_fall_check: assert property (
        @(posedge clk_80MHz) disable iff (!rst_n)
        $fell(draw_ack) |-> (!$past(draw_req) && !draw_req)
    ) else $error("draw_ack fell before draw_req fell");

    ack_rise_check: assert property (
        @(posedge clk_80MHz) disable iff (!rst_n)
        $rose(draw_ack) |-> draw_req    // Only answers a live request.
    ) else $error("draw_ack rose without a request");

endmodule

//--- verification/photon_counter_tb.sv
`timescale 1ns/1ps

module photon_counter_tb
    import photon_pkg::*;
();

    localparam lcd_word_t exp_cmd            = 16'h002c;   // Memory write command.
    localparam lcd_word_t exp_colour         = 16'h001f;   // Colour out of reset.
    localparam int        loop_sync_period   = 40;
    localparam int        loop_photon_period = 8;
    localparam int        loop_frames        = 6;
    localparam int        job_timeout        = 20_000;     // Clocks per wait.
    localparam int        first_sim_timeout  = 2_000_000;  // Old sync period runs out first.
    localparam int        rows               = 4;

    logic      clk_80MHz;
    logic      rst_n;
    logic      photon_pulse;
    logic      sync_50Hz;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    lcd_word_t cfg_wdata;
    lcd_word_t cfg_rdata;
    logic      photon_pulse_simulate;
    logic      sync_50Hz_simulate;
    logic      LCD_RST;
    logic      BL_CTR;
    logic      LCD_CS;
    logic      LCD_RS;
    logic      LCD_WR;
    logic      LCD_RD;
    lcd_word_t LCD_DATA;
    logic      busy;

    // Stimulus table of photon pulses, colour and expected count words.
    int        row_pulses [rows] = '{0, 1, 17, 300};
    lcd_word_t row_colour [rows] = '{16'hf800, 16'h07e0, 16'hffff, 16'h5a5a};
    lcd_word_t row_exp_hi [rows] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000};
    lcd_word_t row_exp_lo [rows] = '{16'h0000, 16'h0001, 16'h0011, 16'h012c};

    logic        mon_rs [$];     // RS of each latched word.
    lcd_word_t   mon_data [$];
    int          bus_base;       // First word of the current job.
    logic [31:0] lfsr;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_bad;
    string       test_name;

    initial begin
        clk_80MHz = 1'b0;
        forever #50 clk_80MHz = ~clk_80MHz;
    end

    photon_counter_top i_photon_counter_top (.*);

    bind display_sequencer photon_counter_properties i_photon_counter_properties (
        .clk_80MHz (clk_80MHz),
        .rst_n     (rst_n),
        .draw_req  (draw_req),
        .draw_job  (draw_job),
        .draw_ack  (draw_ack)
    );

    // Panel latches on the WR rising edge.
    always @(posedge LCD_WR) begin
        mon_rs.push_back(LCD_RS);
        mon_data.push_back(LCD_DATA);
    end

    //////////////////////////////////////////////////
    // Helpers.
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // Galois form.
    endfunction

    task automatic random_gap(output int cycles);
        logic [2:0] bits;
        bits = '0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit.
            bits = {bits[1:0], lfsr[0]};
        end
        cycles = 2 + int'(bits);     // 2 to 9 clocks.
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("tests failed");
        $finish;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_bad++;
            $display("test %s: FAIL, %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: expected %h, got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_80MHz);
        rst_n <= 1'b0;
        repeat (5) @(posedge clk_80MHz);
        check_bit("LCD_CS", LCD_CS, 1'b1);  // Bus idle while held.
        check_bit("LCD_WR", LCD_WR, 1'b1);
        check_bit("LCD_RD", LCD_RD, 1'b1);
        check_bit("busy", busy, 1'b0);
        rst_n <= 1'b1;
    endtask

    task automatic mark_bus();
        bus_base = mon_data.size();
    endtask

    task automatic write_reg(input cfg_addr_t addr, input lcd_word_t data);
        @(posedge clk_80MHz);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk_80MHz);
        cfg_we <= 1'b0;
    endtask

    task automatic check_reg(input cfg_addr_t addr, input lcd_word_t exp);
        @(posedge clk_80MHz);
        cfg_addr <= addr;
        @(posedge clk_80MHz);        // Readback settled.
        assert (cfg_rdata === exp) else begin
            $display("[ERROR] cfg_rdata at address %0d: expected %h, got %h",
                     addr, exp, cfg_rdata);
            errors++;
        end
    endtask

    task automatic pulse_sync();
        @(posedge clk_80MHz);
        sync_50Hz <= 1'b1;
        repeat (2) @(posedge clk_80MHz);
        sync_50Hz <= 1'b0;
    endtask

    task automatic drive_photons(input int count);
        int high_len;
        int low_len;
        for (int i = 0; i < count; i++) begin
            random_gap(high_len);
            random_gap(low_len);
            @(posedge clk_80MHz);
            photon_pulse <= 1'b1;
            repeat (high_len) @(posedge clk_80MHz);
            photon_pulse <= 1'b0;
            repeat (low_len - 1) @(posedge clk_80MHz);
        end
    endtask

    // Waits for the words of the job and for the handshake to close.
    task automatic wait_bus_words(input int count);
        int guard;
        guard = 0;
        while ((mon_data.size() - bus_base < count) && (guard < job_timeout)) begin
            @(posedge clk_80MHz);
            guard++;
        end
        if (mon_data.size() - bus_base < count) begin
            give_up("LCD bus words");
        end
        guard = 0;
        while (busy && (guard < job_timeout)) begin
            @(posedge clk_80MHz);
            guard++;
        end
        if (busy) begin
            give_up("busy to fall");
        end
    endtask

    task automatic check_word_count(input int count);
        assert (mon_data.size() - bus_base == count) else begin
            $display("expected %0d bus words, saw %0d", count, mon_data.size() - bus_base);
            errors++;
        end
    endtask

    task automatic check_word(input int idx, input logic exp_rs, input lcd_word_t exp_data);
        int pos;
        pos = bus_base + idx;
        assert (pos < mon_data.size()) else begin
            $display("bus word %0d of the job was never written", idx);
            errors++;
        end
        if (pos < mon_data.size()) begin
            assert (mon_rs[pos] === exp_rs) else begin
                $display("[ERROR] LCD_RS word %0d: expected %h, got %h", idx, exp_rs, mon_rs[pos]);
                errors++;
            end
            assert (mon_data[pos] === exp_data) else begin
                $display("[ERROR] LCD_DATA word %0d: expected %h, got %h",
                         idx, exp_data, mon_data[pos]);
                errors++;
            end
        end
    endtask

    task automatic check_fixed_job(input lcd_word_t colour);
        check_word(0, 1'b0, exp_cmd);
        for (int i = 1; i <= 4; i++) begin
            check_word(i, 1'b1, colour);  // Fill words.
        end
    endtask

    task automatic check_count_job(input int first, input lcd_word_t hi, input lcd_word_t lo);
        check_word(first, 1'b0, exp_cmd);
        check_word(first + 1, 1'b1, hi);
        check_word(first + 2, 1'b1, lo);
    endtask

    // Simulate outputs fed back to the pins.
    task automatic loop_back_frames(input int frames);
        int seen;
        int gap;
        int guard;
        seen  = 0;
        gap   = 0;
        guard = 0;
        while ((seen < frames) && (guard < first_sim_timeout)) begin
            @(posedge clk_80MHz);
            guard++;
            gap++;
            photon_pulse <= photon_pulse_simulate;
            sync_50Hz    <= sync_50Hz_simulate;
            if (sync_50Hz_simulate) begin
                if (seen > 0) begin
                    assert (gap == loop_sync_period) else begin
                        $display("[ERROR] sync_50Hz_simulate spacing: expected %h, got %h",
                                 loop_sync_period, gap);
                        errors++;
                    end
                end
                gap = 0;
                seen++;
            end
        end
        @(posedge clk_80MHz);
        photon_pulse <= 1'b0;
        sync_50Hz    <= 1'b0;
        if (seen < frames) begin
            give_up("sync_50Hz_simulate pulses");
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence.
    //////////////////////////////////////////////////
    initial begin
        rst_n        <= 1'b0;
        photon_pulse <= 1'b0;
        sync_50Hz    <= 1'b0;
        cfg_we       <= 1'b0;
        cfg_addr     <= '0;
        cfg_wdata    <= '0;
        lfsr        = 32'h92b3869c;
        errors      = 0;
        tests_run   = 0;
        tests_bad   = 0;
        bus_base    = 0;
        test_errors = 0;

        begin_test("reset_fixed_screen");
        apply_reset();
        mark_bus();
        wait_bus_words(5);
        check_word_count(5);
        check_fixed_job(exp_colour);
        check_bit("LCD_RST", LCD_RST, 1'b1);
        check_bit("BL_CTR", BL_CTR, 1'b1);
        end_test();

        // Periods go in early. The default sync period must expire first.
        begin_test("period_registers");
        check_reg(2'd0, exp_colour);
        check_reg(2'd1, 16'h0190);     // 400.
        check_reg(2'd2, 16'h6a00);     // 1,600,000 low half.
        check_reg(2'd3, 16'h0018);
        write_reg(2'd2, 16'(loop_sync_period));
        write_reg(2'd1, 16'(loop_photon_period));
        check_reg(2'd1, 16'(loop_photon_period));
        check_reg(2'd2, 16'(loop_sync_period));
        check_reg(2'd3, 16'h0000);     // Upper byte cleared.
        end_test();

        begin_test("count_rows");
        for (int r = 0; r < rows; r++) begin
            write_reg(2'd0, row_colour[r]);
            check_reg(2'd0, row_colour[r]);
            mark_bus();
            pulse_sync();              // Open the frame.
            wait_bus_words(3);
            mark_bus();
            drive_photons(row_pulses[r]);
            pulse_sync();              // Close it.
            wait_bus_words(3);
            check_word_count(3);
            check_count_job(0, row_exp_hi[r], row_exp_lo[r]);
        end
        end_test();

        // Burst of syncs inside one job.
        begin_test("back_pressure");
        mark_bus();
        pulse_sync();
        repeat (2) @(posedge clk_80MHz);
        pulse_sync();
        repeat (2) @(posedge clk_80MHz);
        pulse_sync();
        wait_bus_words(6);
        repeat (60) @(posedge clk_80MHz);  // Room for a stray third job.
        check_word_count(6);
        check_count_job(0, 16'h0000, 16'h0000);
        check_count_job(3, 16'h0000, 16'h0000);
        check_bit("busy", busy, 1'b0);
        end_test();

        begin_test("loop_back");
        mark_bus();
        loop_back_frames(loop_frames);
        wait_bus_words(3 * loop_frames);
        check_word_count(3 * loop_frames);
        check_word(0, 1'b0, exp_cmd);      // First frame opened before the loop.
        for (int j = 1; j < loop_frames; j++) begin
            check_count_job(3 * j, 16'h0000,
                            lcd_word_t'(loop_sync_period / loop_photon_period));
        end
        end_test();

        begin_test("colour_after_reset");
        write_reg(2'd0, 16'h7bef);
        check_reg(2'd0, 16'h7bef);
        apply_reset();
        mark_bus();
        wait_bus_words(5);
        check_word_count(5);
        check_fixed_job(exp_colour);       // Register back at its default.
        check_reg(2'd0, exp_colour);
        end_test();

        $display("summary: %0d tests run, %0d with errors, %0d checks failed",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
